// File: logic/ExecPkg.sv
`default_nettype none

package ExecPkg;

    parameter int HistBits = 8;

    typedef logic [6:0] SqN;
    typedef logic [6:0] Tag;
    typedef logic [4:0] RegNm;
    typedef logic [HistBits-1:0] BHist;

    typedef enum logic [5:0] {
        IntAdd, IntSub, IntSll, IntSrl, IntSra,
        IntAnd, IntOr, IntXor, IntAndn, IntOrn, IntXnor,
        IntSlt, IntSltu, IntLui, IntAuipc,
        IntSh1add, IntSh2add, IntSh3add,
        IntSeB, IntSeH, IntZeH,
        IntMin, IntMinu, IntMax, IntMaxu,
        IntRev8, IntOrcB, IntClz, IntCtz, IntCpop,
        IntJal, IntJalr,
        IntBeq, IntBne, IntBlt, IntBge, IntBltu, IntBgeu
    } IntOp;

    typedef enum logic [3:0] {
        FlagsNone,
        FlagsBranch,
        FlagsPredTaken,
        FlagsPredNTaken
    } Flags;

    typedef struct packed {
        logic predicted;
        logic taken;
    } BranchPredInfo;

    typedef struct packed {
        logic          valid;
        IntOp          opcode;
        logic [31:0]   srcA;
        logic [31:0]   srcB;
        logic [31:0]   imm;
        logic [31:0]   pc;
        Tag            tagDst;
        RegNm          nmDst;
        SqN            sqN;
        logic          compressed;
        BHist          history;
        BranchPredInfo bpi;
    } ExUop;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        Tag          tagDst;
        RegNm        nmDst;
        SqN          sqN;
        logic [31:0] pc;
        logic        compressed;
        Flags        flags;
    } ResUop;

    typedef struct packed {
        logic        taken;
        SqN          sqN;
        logic [31:0] dstPC;
        BHist        history;
    } BranchProv;

    // True when a is younger than b by the wrapped difference
    function automatic logic sqnYounger(SqN a, SqN b);
        logic signed [$bits(SqN)-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

`default_nettype wire

// File: logic/BitCount.sv
`timescale 1ns/1ps
`default_nettype none

module BitCount (
    input  wire [31:0] word,
    input  wire        countTrailing,
    output logic [5:0] zeroCount,
    output logic [5:0] popCount
);

    logic [31:0] reversed;
    logic [31:0] src;
    logic [31:0] shifted;
    logic [4:0]  lead;

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            reversed[i] = word[31-i];
        end
    end

    assign src = countTrailing ? reversed : word;

    // Halving search where each stage decides one bit of the count
    always_comb begin
        shifted = src;
        lead = '0;
        if (shifted[31:16] == '0) begin
            lead[4] = 1'b1;
            shifted = shifted << 16;
        end
        if (shifted[31:24] == '0) begin
            lead[3] = 1'b1;
            shifted = shifted << 8;
        end
        if (shifted[31:28] == '0) begin
            lead[2] = 1'b1;
            shifted = shifted << 4;
        end
        if (shifted[31:30] == '0) begin
            lead[1] = 1'b1;
            shifted = shifted << 2;
        end
        lead[0] = ~shifted[31];
        zeroCount = (src == '0) ? 6'd32 : {1'b0, lead};
    end

    always_comb begin
        popCount = '0;
        for (int i = 0; i < 32; i++) begin
            popCount = popCount + 6'(word[i]);
        end
    end

endmodule

`default_nettype wire

// File: logic/IntAlu.sv
`timescale 1ns/1ps
`default_nettype none

module IntAlu import ExecPkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire ExUop uop,
    output ResUop     resUop,
    output BranchProv branchOut
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] imm;
    logic [31:0] linkPC;
    logic [31:0] branchImm;
    logic        lessThan;
    logic        lessThanU;
    logic [5:0]  zeroCount;
    logic [5:0]  popCount;
    logic [31:0] result;
    logic        isCond;
    logic        taken;
    logic        redirect;
    logic [31:0] dstPC;
    Flags        flags;
    ResUop       resNext;
    BranchProv   branchNext;

    assign srcA = uop.srcA;
    assign srcB = uop.srcB;
    assign imm = uop.imm;
    assign linkPC = uop.pc + (uop.compressed ? 32'd2 : 32'd4);
    assign branchImm = {{19{imm[12]}}, imm[12:0]};
    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;

    BitCount BitCount_i (
        .word(srcA),
        .countTrailing(uop.opcode == IntCtz),
        .zeroCount(zeroCount),
        .popCount(popCount)
    );

    always_comb begin
        case (uop.opcode)
            IntAdd:    result = srcA + srcB;
            IntSub:    result = srcA - srcB;
            IntSll:    result = srcA << srcB[4:0];
            IntSrl:    result = srcA >> srcB[4:0];
            IntSra:    result = $unsigned($signed(srcA) >>> srcB[4:0]);
            IntAnd:    result = srcA & srcB;
            IntOr:     result = srcA | srcB;
            IntXor:    result = srcA ^ srcB;
            IntAndn:   result = srcA & ~srcB;
            IntOrn:    result = srcA | ~srcB;
            IntXnor:   result = srcA ^ ~srcB;
            IntSlt:    result = {31'b0, lessThan};
            IntSltu:   result = {31'b0, lessThanU};
            IntLui:    result = srcB;
            IntAuipc:  result = uop.pc + imm;
            IntSh1add: result = srcB + (srcA << 1);
            IntSh2add: result = srcB + (srcA << 2);
            IntSh3add: result = srcB + (srcA << 3);
            IntSeB:    result = {{24{srcA[7]}}, srcA[7:0]};
            IntSeH:    result = {{16{srcA[15]}}, srcA[15:0]};
            IntZeH:    result = {16'b0, srcA[15:0]};
            IntMin:    result = lessThan ? srcA : srcB;
            IntMinu:   result = lessThanU ? srcA : srcB;
            IntMax:    result = lessThan ? srcB : srcA;
            IntMaxu:   result = lessThanU ? srcB : srcA;
            IntRev8:   result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            IntOrcB:   result = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                 {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            IntClz,
            IntCtz:    result = {26'b0, zeroCount};
            IntCpop:   result = {26'b0, popCount};
            IntJal,
            IntJalr:   result = linkPC;
            default:   result = '0;
        endcase
    end

    always_comb begin
        isCond = 1'b1;
        case (uop.opcode)
            IntBeq:  taken = srcA == srcB;
            IntBne:  taken = srcA != srcB;
            IntBlt:  taken = lessThan;
            IntBge:  taken = !lessThan;
            IntBltu: taken = lessThanU;
            IntBgeu: taken = !lessThanU;
            default: begin
                isCond = 1'b0;
                taken = (uop.opcode == IntJal) || (uop.opcode == IntJalr);
            end
        endcase

        // JALR is never predicted, so it always redirects
        redirect = (isCond && taken != uop.bpi.taken) || uop.opcode == IntJalr;

        if (uop.opcode == IntJalr)
            dstPC = srcA + srcB;
        else if (uop.opcode == IntJal)
            dstPC = uop.pc + imm;
        else if (isCond && taken)
            dstPC = uop.pc + branchImm;
        else
            dstPC = linkPC;

        if (isCond && uop.bpi.predicted)
            flags = taken ? FlagsPredTaken : FlagsPredNTaken;
        else if (isCond)
            flags = FlagsBranch;
        else
            flags = FlagsNone;
    end

    always_comb begin
        resNext.valid = uop.valid;
        resNext.result = result;
        resNext.tagDst = uop.tagDst;
        resNext.nmDst = uop.nmDst;
        resNext.sqN = uop.sqN;
        resNext.pc = uop.pc;
        resNext.compressed = uop.compressed;
        resNext.flags = flags;

        branchNext.taken = uop.valid && redirect;
        branchNext.sqN = uop.sqN;
        branchNext.dstPC = dstPC;
        if (uop.opcode == IntJal)
            branchNext.history = uop.history;
        else
            branchNext.history = {uop.history[HistBits-2:0], taken};
    end

    always_ff @(posedge clk) begin
        resUop <= resNext;
        branchOut <= branchNext;
        if (!rst) begin
            resUop.valid <= 1'b0;
            branchOut.taken <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/UopDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module UopDispatch import ExecPkg::*; #(
    parameter int NumLanes = 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire ExUop [NumLanes-1:0] issue,
    input  wire [NumLanes-1:0]       wbStall,
    input  wire                      invalidate,
    input  wire SqN                  invalidateSqN,
    output logic [NumLanes-1:0]      issueStall,
    output ExUop [NumLanes-1:0]      laneUop
);

    ExUop              held [NumLanes];
    logic [NumLanes-1:0] killIn;
    logic [NumLanes-1:0] killHeld;

    always_comb begin
        for (int k = 0; k < NumLanes; k++) begin
            killIn[k] = invalidate && sqnYounger(issue[k].sqN, invalidateSqN);
            killHeld[k] = invalidate && sqnYounger(held[k].sqN, invalidateSqN);
            issueStall[k] = held[k].valid && wbStall[k];

            // Valid only in the cycle the ALU takes it
            laneUop[k] = held[k];
            laneUop[k].valid = held[k].valid && !issueStall[k] && !killHeld[k];
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NumLanes; k++) begin
            if (!issueStall[k]) begin
                held[k] <= issue[k];
                held[k].valid <= issue[k].valid && !killIn[k];
            end else begin
                held[k].valid <= !killHeld[k];
            end
            if (!rst)
                held[k].valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/BranchSelect.sv
`timescale 1ns/1ps
`default_nettype none

module BranchSelect import ExecPkg::*; #(
    parameter int NumLanes = 2
) (
    input  wire ResUop [NumLanes-1:0]     laneRes,
    input  wire BranchProv [NumLanes-1:0] laneBranch,
    output ResUop [NumLanes-1:0]          results,
    output BranchProv                     branch
);

    BranchProv oldest;
    logic      replace;

    assign results = laneRes;

    // Running pairwise compare in which the older redirect survives each step
    always_comb begin
        oldest = '0;
        for (int k = 0; k < NumLanes; k++) begin
            replace = laneBranch[k].taken &&
                      (!oldest.taken || sqnYounger(oldest.sqN, laneBranch[k].sqN));
            if (replace)
                oldest = laneBranch[k];
        end
    end

    assign branch = oldest;

endmodule

`default_nettype wire

// File: logic/IntExecCluster.sv
`timescale 1ns/1ps
`default_nettype none

module IntExecCluster import ExecPkg::*; #(
    parameter int NumLanes = 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire ExUop [NumLanes-1:0] issue,
    input  wire [NumLanes-1:0]       wbStall,
    input  wire                      invalidate,
    input  wire SqN                  invalidateSqN,
    output logic [NumLanes-1:0]      issueStall,
    output ResUop [NumLanes-1:0]     results,
    output BranchProv                branch
);

    ExUop [NumLanes-1:0]      laneUop;
    ResUop [NumLanes-1:0]     laneRes;
    BranchProv [NumLanes-1:0] laneBranch;

    UopDispatch #(
        .NumLanes(NumLanes)
    ) UopDispatch_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .issueStall(issueStall),
        .laneUop(laneUop)
    );

    for (genvar k = 0; k < NumLanes; k++) begin : gLane
        IntAlu IntAlu_i (
            .clk(clk),
            .rst(rst),
            .uop(laneUop[k]),
            .resUop(laneRes[k]),
            .branchOut(laneBranch[k])
        );
    end

    BranchSelect #(
        .NumLanes(NumLanes)
    ) BranchSelect_i (
        .laneRes(laneRes),
        .laneBranch(laneBranch),
        .results(results),
        .branch(branch)
    );

endmodule

`default_nettype wire

// File: tb/ClusterModel.svh
`ifndef CLUSTER_MODEL_SVH
`define CLUSTER_MODEL_SVH

function automatic logic isCondOp(IntOp op);
    return op inside {IntBeq, IntBne, IntBlt, IntBge, IntBltu, IntBgeu};
endfunction

function automatic logic modelTaken(ExUop u);
    case (u.opcode)
        IntBeq:  return u.srcA == u.srcB;
        IntBne:  return u.srcA != u.srcB;
        IntBlt:  return $signed(u.srcA) < $signed(u.srcB);
        IntBge:  return $signed(u.srcA) >= $signed(u.srcB);
        IntBltu: return u.srcA < u.srcB;
        IntBgeu: return u.srcA >= u.srcB;
        IntJal, IntJalr: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] modelResult(ExUop u);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    int n;
    a = u.srcA;
    b = u.srcB;
    r = '0;
    n = 0;
    case (u.opcode)
        IntAdd:    r = a + b;
        IntSub:    r = a - b;
        IntSll:    r = a << b[4:0];
        IntSrl:    r = a >> b[4:0];
        IntSra:    r = 32'({{32{a[31]}}, a} >> b[4:0]);
        IntAnd:    r = a & b;
        IntOr:     r = a | b;
        IntXor:    r = a ^ b;
        IntAndn:   r = a & ~b;
        IntOrn:    r = a | ~b;
        IntXnor:   r = ~(a ^ b);
        IntSlt:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        IntSltu:   r = (a < b) ? 32'd1 : 32'd0;
        // Upper immediate arrives already shifted on operand B
        IntLui:    r = b;
        IntAuipc:  r = u.pc + u.imm;
        IntSh1add: r = (a << 1) + b;
        IntSh2add: r = (a << 2) + b;
        IntSh3add: r = (a << 3) + b;
        IntSeB:    r = {{24{a[7]}}, a[7:0]};
        IntSeH:    r = {{16{a[15]}}, a[15:0]};
        IntZeH:    r = {16'h0000, a[15:0]};
        IntMin:    r = ($signed(a) <= $signed(b)) ? a : b;
        IntMinu:   r = (a <= b) ? a : b;
        IntMax:    r = ($signed(a) >= $signed(b)) ? a : b;
        IntMaxu:   r = (a >= b) ? a : b;
        IntRev8: begin
            for (int i = 0; i < 4; i++)
                r[8*i +: 8] = a[8*(3-i) +: 8];
        end
        IntOrcB: begin
            for (int i = 0; i < 4; i++)
                r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hFF : 8'h00;
        end
        IntClz: begin
            for (int i = 31; i >= 0 && !a[i]; i--)
                n++;
            r = 32'(n);
        end
        IntCtz: begin
            for (int i = 0; i < 32 && !a[i]; i++)
                n++;
            r = 32'(n);
        end
        IntCpop: begin
            for (int i = 0; i < 32; i++)
                n += a[i];
            r = 32'(n);
        end
        IntJal, IntJalr: r = u.pc + (u.compressed ? 32'd2 : 32'd4);
        default:   r = '0;
    endcase
    return r;
endfunction

function automatic logic [31:0] modelDst(ExUop u);
    if (u.opcode == IntJalr)
        return u.srcA + u.srcB;
    if (u.opcode == IntJal)
        return u.pc + u.imm;
    if (isCondOp(u.opcode) && modelTaken(u))
        return u.pc + {{19{u.imm[12]}}, u.imm[12:0]};
    return u.pc + (u.compressed ? 32'd2 : 32'd4);
endfunction

function automatic logic modelRedirect(ExUop u);
    if (u.opcode == IntJalr)
        return 1'b1;
    return isCondOp(u.opcode) && (modelTaken(u) != u.bpi.taken);
endfunction

function automatic BHist modelHistory(ExUop u);
    if (u.opcode == IntJal)
        return u.history;
    return {u.history[HistBits-2:0], modelTaken(u)};
endfunction

function automatic Flags modelFlags(ExUop u);
    if (!isCondOp(u.opcode))
        return FlagsNone;
    if (!u.bpi.predicted)
        return FlagsBranch;
    return modelTaken(u) ? FlagsPredTaken : FlagsPredNTaken;
endfunction

// a is older than b when b lies 1 to 63 steps ahead on the wrapped ring
function automatic logic isOlder(SqN a, SqN b);
    SqN gap;
    gap = b - a;
    return (gap != '0) && !gap[6];
endfunction

`endif

// File: tb/IntExecClusterTb.sv
`timescale 1ns/1ps
`default_nettype none

module IntExecClusterTb import ExecPkg::*; ();

    localparam int NumLanes = 2;
    localparam int NumTests = 6;

    logic                     clk;
    logic                     rst;
    ExUop [NumLanes-1:0]      issue;
    logic [NumLanes-1:0]      wbStall;
    logic                     invalidate;
    SqN                       invalidateSqN;
    logic [NumLanes-1:0]      issueStall;
    ResUop [NumLanes-1:0]     results;
    BranchProv                branch;
    logic [15:0]              lfsr;

    `include "ClusterModel.svh"

    IntExecCluster #(
        .NumLanes(NumLanes)
    ) IntExecCluster_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .issueStall(issueStall),
        .results(results),
        .branch(branch)
    );

    always #5 clk = ~clk;

    initial begin
        #(NumTests * 200 * 10);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $fatal(1);
    end

    // Taps 16, 14, 13, 11
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], lfsrBit()};
        return w;
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        if (got !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    function automatic ExUop makeUop(IntOp op, logic [31:0] a, logic [31:0] b,
                                     logic [31:0] immv, SqN sqn);
        ExUop u;
        u = '0;
        u.valid = 1'b1;
        u.opcode = op;
        u.srcA = a;
        u.srcB = b;
        u.imm = immv;
        u.pc = 32'h0000_8000 + 32'(sqn) * 4;
        u.tagDst = sqn ^ 7'h2A;
        u.nmDst = sqn[4:0] + 5'd1;
        u.sqN = sqn;
        u.history = 8'h5A;
        return u;
    endfunction

    task automatic checkResult(input int k, input ExUop u);
        checkValue(results[k].valid, 1'b1, $sformatf("lane %0d valid", k));
        if (!isCondOp(u.opcode))
            checkValue(results[k].result, modelResult(u), $sformatf("lane %0d result", k));
        checkValue(results[k].flags, modelFlags(u), $sformatf("lane %0d flags", k));
        checkValue(results[k].tagDst, u.tagDst, $sformatf("lane %0d tagDst", k));
        checkValue(results[k].nmDst, u.nmDst, $sformatf("lane %0d nmDst", k));
        checkValue(results[k].sqN, u.sqN, $sformatf("lane %0d sqN", k));
        checkValue(results[k].pc, u.pc, $sformatf("lane %0d pc", k));
        checkValue(results[k].compressed, u.compressed, $sformatf("lane %0d compressed", k));
    endtask

    // Two-cycle latency from issue to results
    task automatic runPair(input ExUop u0, input ExUop u1);
        issue[0] = u0;
        issue[1] = u1;
        nextCycle();
        issue = '0;
        nextCycle();
        checkResult(0, u0);
        if (u1.valid)
            checkResult(1, u1);
        else
            checkValue(results[1].valid, 1'b0, "idle lane 1 valid");
    endtask

    task automatic checkRedirect(input ExUop u);
        checkValue(branch.taken, modelRedirect(u), "redirect");
        if (modelRedirect(u)) begin
            checkValue(branch.sqN, u.sqN, "redirect sqN");
            checkValue(branch.dstPC, modelDst(u), "redirect dstPC");
            checkValue(branch.history, modelHistory(u), "redirect history");
        end
    endtask

    task automatic testArithmetic();
        for (int rep = 0; rep < 2; rep++) begin
            for (int op = 0; op <= int'(IntCpop); op++) begin
                runPair(makeUop(IntOp'(op), randomWord(), randomWord(), randomWord(), SqN'(op)),
                        makeUop(IntOp'(op), randomWord(), randomWord(), randomWord(),
                                SqN'(op + 64)));
            end
        end
    endtask

    task automatic testBitOps();
        logic [31:0] words [7] = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000,
                                   32'h0001_0000, 32'h1234_5678, 32'h00FF_0080};
        IntOp ops [8] = '{IntClz, IntCtz, IntCpop, IntRev8, IntOrcB, IntSeB, IntSeH, IntZeH};
        for (int w = 0; w < 7; w++) begin
            for (int o = 0; o < 8; o++)
                runPair(makeUop(ops[o], words[w], '0, '0, 7'd3),
                        makeUop(ops[o], ~words[w], '0, '0, 7'd4));
        end
    endtask

    task automatic testBranches();
        IntOp conds [6] = '{IntBeq, IntBne, IntBlt, IntBge, IntBltu, IntBgeu};
        logic [31:0] aVals [3] = '{32'hFFFF_FFFE, 32'd5, 32'd3};
        logic [31:0] bVals [3] = '{32'd3, 32'd5, 32'hFFFF_FFFE};
        logic [31:0] immVals [3] = '{32'hABCD_1FF0, 32'h0000_0040, 32'h1234_0FFC};
        ExUop u;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 4; p++) begin
                for (int v = 0; v < 3; v++) begin
                    u = makeUop(conds[c], aVals[v], bVals[v], immVals[v], 7'd9);
                    u.bpi = BranchPredInfo'(p[1:0]);
                    runPair(u, '0);
                    checkRedirect(u);
                end
            end
        end
        for (int cmp = 0; cmp < 2; cmp++) begin
            u = makeUop(IntJal, '0, '0, 32'h0000_0120, 7'd11);
            u.compressed = cmp[0];
            runPair(u, '0);
            checkRedirect(u);
        end
        u = makeUop(IntJalr, 32'h0000_4000, randomWord(), '0, 7'd12);
        runPair(u, '0);
        checkRedirect(u);
    endtask

    task automatic testOldest();
        SqN firstSqN [4] = '{7'd10, 7'd20, 7'd126, 7'd2};
        SqN secondSqN [4] = '{7'd20, 7'd10, 7'd2, 7'd126};
        ExUop u0;
        ExUop u1;
        ExUop older;
        for (int i = 0; i < 4; i++) begin
            u0 = makeUop(IntBeq, 32'd7, 32'd7, 32'h0000_0100, firstSqN[i]);
            u1 = makeUop(IntBeq, 32'd7, 32'd7, 32'h0000_0100, secondSqN[i]);
            runPair(u0, u1);
            older = isOlder(u0.sqN, u1.sqN) ? u0 : u1;
            checkValue(branch.taken, 1'b1, "oldest redirect taken");
            checkValue(branch.sqN, older.sqN, "oldest redirect sqN");
            checkValue(branch.dstPC, modelDst(older), "oldest redirect dstPC");
        end
    endtask

    task automatic testFlush();
        ExUop u0;
        ExUop u1;
        // Killed on the way into dispatch
        u0 = makeUop(IntAdd, 32'd1, 32'd2, '0, 7'd10);
        u1 = makeUop(IntAdd, 32'd3, 32'd4, '0, 7'd30);
        issue[0] = u0;
        issue[1] = u1;
        invalidate = 1'b1;
        invalidateSqN = 7'd20;
        nextCycle();
        issue = '0;
        invalidate = 1'b0;
        nextCycle();
        checkResult(0, u0);
        checkValue(results[1].valid, 1'b0, "flushed incoming lane 1 valid");
        // Killed while held across the sequence wrap
        u0 = makeUop(IntSub, 32'd9, 32'd5, '0, 7'd120);
        u1 = makeUop(IntSub, 32'd8, 32'd6, '0, 7'd3);
        issue[0] = u0;
        issue[1] = u1;
        nextCycle();
        issue = '0;
        invalidate = 1'b1;
        invalidateSqN = 7'd120;
        nextCycle();
        invalidate = 1'b0;
        checkResult(0, u0);
        checkValue(results[1].valid, 1'b0, "flushed held lane 1 valid");
        nextCycle();
        checkValue(results[1].valid, 1'b0, "late result from flushed lane 1");
        // Killed while stalled in dispatch
        u1 = makeUop(IntOr, 32'd1, 32'd6, '0, 7'd50);
        wbStall = 2'b10;
        issue[1] = u1;
        nextCycle();
        issue = '0;
        invalidate = 1'b1;
        invalidateSqN = 7'd45;
        nextCycle();
        invalidate = 1'b0;
        checkValue(issueStall, 2'b00, "issueStall after flushing stalled lane 1");
        wbStall = '0;
        repeat (2) begin
            nextCycle();
            checkValue(results[1].valid, 1'b0, "result from flushed stalled lane 1");
        end
    endtask

    task automatic testStall();
        ExUop u0;
        ExUop u1;
        ExUop u2;
        int waited;
        u0 = makeUop(IntXor, randomWord(), randomWord(), '0, 7'd40);
        u1 = makeUop(IntOr, randomWord(), randomWord(), '0, 7'd41);
        u2 = makeUop(IntAnd, randomWord(), randomWord(), '0, 7'd42);
        wbStall = 2'b10;
        nextCycle();
        checkValue(issueStall, 2'b00, "issueStall on empty lane");
        issue[0] = u0;
        issue[1] = u1;
        nextCycle();
        issue[0] = u2;
        issue[1] = '0;
        checkValue(issueStall, 2'b10, "issueStall after capture");
        nextCycle();
        issue = '0;
        checkResult(0, u0);
        checkValue(results[1].valid, 1'b0, "stalled lane 1 valid");
        nextCycle();
        checkResult(0, u2);
        checkValue(results[1].valid, 1'b0, "stalled lane 1 valid");
        repeat (2) begin
            nextCycle();
            checkValue(issueStall, 2'b10, "issueStall while held");
            checkValue(results[0].valid, 1'b0, "idle lane 0 valid");
            checkValue(results[1].valid, 1'b0, "stalled lane 1 valid");
        end
        wbStall = '0;
        waited = 0;
        while (!results[1].valid) begin
            if (waited == 8) begin
                $display("Stalled micro-op on lane 1 never produced a result");
                $display(">>> FAIL");
                $fatal(1);
            end
            nextCycle();
            waited++;
        end
        checkResult(1, u1);
        checkValue(issueStall, 2'b00, "issueStall after release");
        nextCycle();
        checkValue(results[1].valid, 1'b0, "second result from stalled micro-op");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        issue = '0;
        wbStall = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        lfsr = 16'd6;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        checkValue(results[0].valid, 1'b0, "lane 0 valid after reset");
        checkValue(results[1].valid, 1'b0, "lane 1 valid after reset");
        checkValue(branch.taken, 1'b0, "branch taken after reset");
        checkValue(issueStall, 2'b00, "issueStall after reset");
        testArithmetic();
        testBitOps();
        testBranches();
        testOldest();
        testFlush();
        testStall();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: IntExecCluster.f
+incdir+tb
logic/ExecPkg.sv
logic/BitCount.sv
logic/IntAlu.sv
logic/UopDispatch.sv
logic/BranchSelect.sv
logic/IntExecCluster.sv
tb/IntExecClusterTb.sv
